//--- compile.f
source/mask_alu_pkg.sv
source/mask_uop_decode.sv
source/mask_logic_unit.sv
source/mask_set_first.sv
source/mask_reduce.sv
source/mask_result_stage.sv
source/mask_alu.sv
tests/mask_alu_checker.sv
tests/mask_alu_tb.sv

//--- Bender.yml
package:
  name: mask_alu

sources:
  - files:
      - source/mask_alu_pkg.sv
      - source/mask_uop_decode.sv
      - source/mask_logic_unit.sv
      - source/mask_set_first.sv
      - source/mask_reduce.sv
      - source/mask_result_stage.sv
      - source/mask_alu.sv
  - target: test
    files:
      - tests/mask_alu_checker.sv
      - tests/mask_alu_tb.sv

//--- tests/mask_alu_tb.sv
`timescale 1ns/10ps

module mask_alu_tb;
  import mask_alu_pkg::*;

  localparam int run_cycles     = 3000;
  // reset, drain and some slack on top of the run
  localparam int timeout_cycles = run_cycles + 100;

  logic        clk;
  logic        reset;
  logic        uop_valid;
  mask_uop_t   uop;
  logic        result_valid;
  rob_result_t result;

  logic [31:0] lfsr = 32'h60bf;
  int          cycle_count = 0;
  int          error_count = 0;
  logic        valid_q[$];
  rob_result_t result_q[$];

  mask_alu dut (
    .clk          (clk),
    .reset        (reset),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (result_valid),
    .result       (result)
  );

  bind mask_alu mask_alu_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .uop_valid    (uop_valid),
    .accept       (accept),
    .operands     (operands),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not end within %0d cycles", timeout_cycles);
      $display("Test failed");
      $fatal(1, "run stopped by timeout");
    end
  end

  // galois form, taps 32 22 2 1
  function automatic vreg_t take_bits(input int n);
    vreg_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = {v[vlen-2:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic compare(input string name, input vreg_t actual, input vreg_t expected);
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      $display("Test failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic model_uop(input logic valid, input mask_uop_t u, output logic acc,
                           output rob_result_t r);
    logic  is_logic;
    logic  is_reduce;
    logic  is_sf;
    logic  seen;
    logic  s;
    logic  a;
    logic  b;
    int    cnt;
    int    first;
    vreg_t w;
    is_logic  = u.funct3 == funct3_opmvv && u.funct6[5:3] == 3'b011;
    is_reduce = u.funct3 == funct3_opmvv && u.funct6 == funct6_vwxunary0 &&
                (u.vs1 == vs1_vcpop || u.vs1 == vs1_vfirst);
    is_sf     = u.funct3 == funct3_opmvv && u.funct6 == funct6_vmunary0 &&
                (u.vs1 inside {vs1_vmsbf, vs1_vmsif, vs1_vmsof});
    acc = 1'b0;
    if (valid && is_logic)
      acc = u.vs1_data_valid && u.vs2_data_valid && u.vd_data_valid && u.vm;
    else if (valid && is_reduce)
      acc = !u.vs1_data_valid && u.vs2_data_valid && (u.vm || u.v0_data_valid);
    else if (valid && is_sf)
      acc = !u.vs1_data_valid && u.vs2_data_valid &&
            (u.vm || (u.v0_data_valid && u.vd_data_valid));
    cnt   = 0;
    first = -1;
    seen  = 1'b0;
    w     = '0;
    for (int i = 0; i < vlen; i++) begin
      a = u.vs2_data[i];
      b = u.vs1_data[i];
      // active source bit of a unary op
      s = a && i < u.vl && (u.vm || u.v0_data[i]);
      if (is_logic) begin
        case (u.funct6[2:0])
          3'd0: w[i] = a & ~b;
          3'd1: w[i] = a & b;
          3'd2: w[i] = a | b;
          3'd3: w[i] = a ^ b;
          3'd4: w[i] = a | ~b;
          3'd5: w[i] = ~(a & b);
          3'd6: w[i] = ~(a | b);
          default: w[i] = ~(a ^ b);
        endcase
        if (i < u.vstart)
          w[i] = u.vd_data[i];
      end else if (is_sf) begin
        case (u.vs1)
          vs1_vmsbf: w[i] = !seen && !s;
          vs1_vmsif: w[i] = !seen;
          default:   w[i] = !seen && s;
        endcase
        if (!u.vm && i < u.vl && !u.v0_data[i])
          w[i] = u.vd_data[i];
      end
      if (s && !seen)
        first = i;
      if (s) begin
        cnt++;
        seen = 1'b1;
      end
    end
    if (is_reduce)
      w = (u.vs1 == vs1_vcpop) ? vreg_t'(xreg_t'(cnt)) : vreg_t'(xreg_t'(first));
    r.rob_entry  = u.rob_entry;
    r.w_data     = w;
    r.ignore_vta = is_logic || is_sf;
    r.ignore_vma = is_sf;
  endtask

  task automatic drive_uop();
    logic [3:0]  pick;
    logic        v;
    logic        unary;
    logic        acc;
    mask_uop_t   u;
    rob_result_t r;
    v           = take_bits(3) != 0;
    pick        = 4'(take_bits(4));
    unary       = pick >= 4'd8;
    u.rob_entry = rob_idx_t'(take_bits(rob_idx_width));
    u.funct3    = funct3_opmvv;
    u.vs1       = 5'(take_bits(5));
    if (pick < 4'd8) begin
      u.funct6 = {3'b011, pick[2:0]};
    end else if (pick < 4'd10) begin
      u.funct6 = funct6_vwxunary0;
      u.vs1    = pick[0] ? vs1_vfirst : vs1_vcpop;
    end else if (pick < 4'd13) begin
      u.funct6 = funct6_vmunary0;
      u.vs1    = (pick == 4'd10) ? vs1_vmsbf : (pick == 4'd11) ? vs1_vmsif : vs1_vmsof;
    end else if (pick == 4'd13) begin
      u.funct6 = {3'b011, 3'(take_bits(3))};
      u.funct3 = 3'(take_bits(3));
    end else begin
      // mostly unsupported encodings
      u.funct6 = 6'(take_bits(6));
    end
    u.vl       = vl_t'(take_bits(8) % (vlen + 1));
    u.vstart   = vl_t'(take_bits(8) % (vlen + 1));
    u.vm       = take_bits(3) != 0;
    u.v0_data  = take_bits(vlen);
    u.vd_data  = take_bits(vlen);
    u.vs1_data = take_bits(vlen);
    u.vs2_data = take_bits(vlen);
    // empty and sparse sources for the set-first and vfirst corners
    if (take_bits(3) == 0)
      u.vs2_data = '0;
    else if (take_bits(2) == 0)
      u.vs2_data = u.vs2_data & take_bits(vlen) & take_bits(vlen);
    u.v0_data_valid  = take_bits(4) != 0;
    u.vd_data_valid  = take_bits(4) != 0;
    u.vs2_data_valid = take_bits(4) != 0;
    u.vs1_data_valid = unary ? (take_bits(4) == 0) : (take_bits(4) != 0);
    uop_valid = v;
    uop       = u;
    model_uop(v, u, acc, r);
    valid_q.push_back(acc);
    result_q.push_back(r);
  endtask

  task automatic check_outputs();
    logic        exp_valid;
    rob_result_t exp;
    if (dut.u_checker.fail_count != 0) begin
      error_count++;
      $display("an assertion in the bound checker failed");
      $display("Test failed");
      $fatal(1, "stopped at first error");
    end
    exp_valid = valid_q.pop_front();
    exp       = result_q.pop_front();
    compare("result_valid", vreg_t'(result_valid), vreg_t'(exp_valid));
    if (exp_valid) begin
      compare("rob_entry", vreg_t'(result.rob_entry), vreg_t'(exp.rob_entry));
      compare("w_data", result.w_data, exp.w_data);
      compare("ignore_vta", vreg_t'(result.ignore_vta), vreg_t'(exp.ignore_vta));
      compare("ignore_vma", vreg_t'(result.ignore_vma), vreg_t'(exp.ignore_vma));
    end
  endtask

  initial begin
    reset     = 1'b1;
    uop_valid = 1'b0;
    uop       = '0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    // first cycle out of reset must be idle
    valid_q.push_back(1'b0);
    result_q.push_back('0);
    for (int c = 0; c < run_cycles; c++) begin
      @(posedge clk);
      #1;
      check_outputs();
      drive_uop();
    end
    @(posedge clk);
    #1;
    check_outputs();
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- tests/mask_alu_checker.sv
`timescale 1ns/10ps

module mask_alu_checker (
  input logic                         clk,
  input logic                         reset,
  input logic                         uop_valid,
  input logic                         accept,
  input mask_alu_pkg::mask_operands_t operands,
  input logic                         result_valid,
  input mask_alu_pkg::rob_result_t    result
);
  import mask_alu_pkg::*;

  int fail_count = 0;

  // output idle right after reset
  a_reset_idle: assert property (
    @(posedge clk) reset |=> !result_valid
  ) else begin
    $error("result_valid high in the cycle after reset");
    fail_count = fail_count + 1;
  end

  // every result comes from an issued uop
  a_valid_source: assert property (
    @(posedge clk) disable iff (reset)
    result_valid |-> $past(uop_valid)
  ) else begin
    $error("result_valid without uop_valid in the previous cycle");
    fail_count = fail_count + 1;
  end

  // reductions only fill the scalar bits
  a_reduce_upper_zero: assert property (
    @(posedge clk) disable iff (reset)
    (accept && (operands.op inside {op_vcpop, op_vfirst}))
      |=> (result.w_data[vlen-1:xlen] == '0)
  ) else begin
    $error("reduction result has bits set above xlen");
    fail_count = fail_count + 1;
  end

endmodule

//--- source/mask_alu.sv
`timescale 1ns/10ps

module mask_alu (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      uop_valid,
  input  mask_alu_pkg::mask_uop_t   uop,
  output logic                      result_valid,
  output mask_alu_pkg::rob_result_t result
);
  import mask_alu_pkg::*;

  logic           accept;
  mask_operands_t operands;
  vreg_t          logic_data;
  vreg_t          set_first_data;
  vreg_t          reduce_data;

  mask_uop_decode u_decode (
    .uop_valid (uop_valid),
    .uop       (uop),
    .accept    (accept),
    .operands  (operands)
  );

  mask_logic_unit u_logic (
    .operands   (operands),
    .logic_data (logic_data)
  );

  mask_set_first u_set_first (
    .operands       (operands),
    .set_first_data (set_first_data)
  );

  mask_reduce u_reduce (
    .operands    (operands),
    .reduce_data (reduce_data)
  );

  mask_result_stage u_result (
    .clk            (clk),
    .reset          (reset),
    .accept         (accept),
    .operands       (operands),
    .logic_data     (logic_data),
    .set_first_data (set_first_data),
    .reduce_data    (reduce_data),
    .result_valid   (result_valid),
    .result         (result)
  );

endmodule

//--- source/mask_result_stage.sv
`timescale 1ns/10ps

module mask_result_stage (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         accept,
  input  mask_alu_pkg::mask_operands_t operands,
  input  mask_alu_pkg::vreg_t          logic_data,
  input  mask_alu_pkg::vreg_t          set_first_data,
  input  mask_alu_pkg::vreg_t          reduce_data,
  output logic                         result_valid,
  output mask_alu_pkg::rob_result_t    result
);
  import mask_alu_pkg::*;

  logic        is_logic;
  logic        is_set_first;
  vreg_t       op_data;
  rob_result_t next_result;

  // pick the unit that owns this op
  always_comb begin
    is_logic     = 1'b0;
    is_set_first = 1'b0;
    op_data      = '0;
    case (operands.op)
      op_vmandn, op_vmand, op_vmor, op_vmxor,
      op_vmorn, op_vmnand, op_vmnor, op_vmxnor: begin
        is_logic = 1'b1;
        op_data  = logic_data;
      end
      op_vcpop, op_vfirst: begin
        op_data = reduce_data;
      end
      op_vmsbf, op_vmsif, op_vmsof: begin
        is_set_first = 1'b1;
        op_data      = set_first_data;
      end
      default: begin
        op_data = '0;
      end
    endcase
  end

  always_comb begin
    next_result.rob_entry  = operands.rob_entry;
    // prestart and masked-off bits come from old vd
    next_result.w_data     = (op_data & ~operands.keep_vd) |
                             (operands.vd_data & operands.keep_vd);
    next_result.ignore_vta = is_logic | is_set_first;
    next_result.ignore_vma = is_set_first;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= accept;
    end
  end

  // record only moves on an accepted uop
  always_ff @(posedge clk) begin
    if (accept) begin
      result <= next_result;
    end
  end

endmodule

//--- source/mask_reduce.sv
`timescale 1ns/10ps

module mask_reduce (
  input  mask_alu_pkg::mask_operands_t operands,
  output mask_alu_pkg::vreg_t          reduce_data
);
  import mask_alu_pkg::*;

  localparam int group_width = 16;
  localparam int group_count = vlen / group_width;
  localparam int part_width  = $clog2(group_width + 1);
  localparam int count_width = $clog2(vlen + 1);
  localparam int index_width = $clog2(vlen);

  logic [group_count-1:0][part_width-1:0] partial_count;
  logic [count_width-1:0]                 pop_count;
  logic [index_width-1:0]                 first_index;
  logic                                   found;
  xreg_t                                  scalar;

  // 16-bit slices counted on their own
  always_comb begin
    for (int g = 0; g < group_count; g++) begin
      partial_count[g] = '0;
      for (int b = 0; b < group_width; b++) begin
        partial_count[g] = partial_count[g] +
                           part_width'(operands.src2[g*group_width + b]);
      end
    end
  end

  always_comb begin
    pop_count = '0;
    for (int g = 0; g < group_count; g++) begin
      pop_count = pop_count + count_width'(partial_count[g]);
    end
  end

  // scan down so the lowest set bit wins
  always_comb begin
    found       = 1'b0;
    first_index = '0;
    for (int i = vlen - 1; i >= 0; i--) begin
      if (operands.src2[i]) begin
        found       = 1'b1;
        first_index = index_width'(i);
      end
    end
  end

  always_comb begin
    case (operands.op)
      op_vcpop: begin
        scalar = xreg_t'(pop_count);
      end
      op_vfirst: begin
        // -1 when no bit is set
        scalar = found ? xreg_t'(first_index) : '1;
      end
      default: begin
        scalar = '0;
      end
    endcase
  end

  assign reduce_data = vreg_t'(scalar);

endmodule

//--- source/mask_set_first.sv
`timescale 1ns/10ps

module mask_set_first (
  input  mask_alu_pkg::mask_operands_t operands,
  output mask_alu_pkg::vreg_t          set_first_data
);
  import mask_alu_pkg::*;

  vreg_t src;
  vreg_t first_bit;
  vreg_t below_first;

  assign src = operands.src2;

  // one-hot lowest set bit, zero when src is empty
  assign first_bit = src & ~(src - vreg_t'(1));

  // everything under the first set bit
  // an empty source wraps to all ones here
  assign below_first = first_bit - vreg_t'(1);

  always_comb begin
    case (operands.op)
      op_vmsbf: begin
        set_first_data = below_first;
      end
      op_vmsif: begin
        set_first_data = below_first | first_bit;
      end
      op_vmsof: begin
        set_first_data = first_bit;
      end
      default: begin
        set_first_data = '0;
      end
    endcase
  end

endmodule

//--- source/mask_logic_unit.sv
`timescale 1ns/10ps

module mask_logic_unit (
  input  mask_alu_pkg::mask_operands_t operands,
  output mask_alu_pkg::vreg_t          logic_data
);
  import mask_alu_pkg::*;

  vreg_t a;
  vreg_t b;

  // vs2 is the left operand
  assign a = operands.src2;
  assign b = operands.src1;

  always_comb begin
    case (operands.op)
      op_vmandn: begin
        logic_data = a & ~b;
      end
      op_vmand: begin
        logic_data = a & b;
      end
      op_vmor: begin
        logic_data = a | b;
      end
      op_vmxor: begin
        logic_data = a ^ b;
      end
      op_vmorn: begin
        logic_data = a | ~b;
      end
      op_vmnand: begin
        logic_data = ~(a & b);
      end
      op_vmnor: begin
        logic_data = ~(a | b);
      end
      op_vmxnor: begin
        logic_data = ~(a ^ b);
      end
      default: begin
        logic_data = '0;
      end
    endcase
  end

endmodule

//--- source/mask_uop_decode.sv
`timescale 1ns/10ps

module mask_uop_decode (
  input  logic                         uop_valid,
  input  mask_alu_pkg::mask_uop_t      uop,
  output logic                         accept,
  output mask_alu_pkg::mask_operands_t operands
);
  import mask_alu_pkg::*;

  mask_op_e op;
  logic     is_logic;
  logic     is_reduce;
  logic     is_set_first;
  vreg_t    body_mask;
  vreg_t    prestart_mask;
  vreg_t    active_mask;

  // element position masks from vl and vstart
  always_comb begin
    for (int i = 0; i < vlen; i++) begin
      body_mask[i]     = i < int'(uop.vl);
      prestart_mask[i] = i < int'(uop.vstart);
    end
  end

  always_comb begin
    op = op_none;
    if (uop.funct3 == funct3_opmvv) begin
      case (uop.funct6)
        funct6_vmandn: op = op_vmandn;
        funct6_vmand:  op = op_vmand;
        funct6_vmor:   op = op_vmor;
        funct6_vmxor:  op = op_vmxor;
        funct6_vmorn:  op = op_vmorn;
        funct6_vmnand: op = op_vmnand;
        funct6_vmnor:  op = op_vmnor;
        funct6_vmxnor: op = op_vmxnor;
        funct6_vwxunary0: begin
          if (uop.vs1 == vs1_vcpop)
            op = op_vcpop;
          else if (uop.vs1 == vs1_vfirst)
            op = op_vfirst;
        end
        funct6_vmunary0: begin
          case (uop.vs1)
            vs1_vmsbf: op = op_vmsbf;
            vs1_vmsif: op = op_vmsif;
            vs1_vmsof: op = op_vmsof;
            default:   op = op_none;
          endcase
        end
        default: op = op_none;
      endcase
    end
  end

  always_comb begin
    is_logic     = 1'b0;
    is_reduce    = 1'b0;
    is_set_first = 1'b0;
    case (op)
      op_vmandn, op_vmand, op_vmor, op_vmxor,
      op_vmorn, op_vmnand, op_vmnor, op_vmxnor: is_logic = 1'b1;
      op_vcpop, op_vfirst:                      is_reduce = 1'b1;
      op_vmsbf, op_vmsif, op_vmsof:             is_set_first = 1'b1;
      default: ;
    endcase
  end

  // operand readiness per group
  always_comb begin
    accept = 1'b0;
    if (uop_valid) begin
      if (is_logic)
        accept = uop.vs1_data_valid & uop.vs2_data_valid & uop.vd_data_valid & uop.vm;
      else if (is_reduce)
        accept = !uop.vs1_data_valid & uop.vs2_data_valid & (uop.vm | uop.v0_data_valid);
      else if (is_set_first)
        accept = !uop.vs1_data_valid & uop.vs2_data_valid &
                 (uop.vm | (uop.v0_data_valid & uop.vd_data_valid));
    end
  end

  // unary ops only see body elements that are enabled by v0
  assign active_mask = uop.vm ? body_mask : (body_mask & uop.v0_data);

  always_comb begin
    operands.rob_entry = uop.rob_entry;
    operands.op        = op;
    operands.vd_data   = uop.vd_data;
    operands.src1      = '0;
    operands.src2      = '0;
    operands.keep_vd   = '0;
    if (is_logic) begin
      operands.src1    = uop.vs1_data;
      operands.src2    = uop.vs2_data;
      operands.keep_vd = prestart_mask;
    end else if (is_reduce || is_set_first) begin
      operands.src2 = uop.vs2_data & active_mask;
      // masked-off body bits are undisturbed
      if (is_set_first && !uop.vm)
        operands.keep_vd = body_mask & ~uop.v0_data;
    end
  end

endmodule

//--- source/mask_alu_pkg.sv
package mask_alu_pkg;

  // register and scalar widths
  localparam int vlen          = 128;
  localparam int xlen          = 32;
  localparam int rob_idx_width = 4;
  // vl and vstart must hold vlen itself
  localparam int vl_width      = 8;

  typedef logic [vlen-1:0]          vreg_t;
  typedef logic [xlen-1:0]          xreg_t;
  typedef logic [rob_idx_width-1:0] rob_idx_t;
  typedef logic [vl_width-1:0]      vl_t;

  localparam logic [2:0] funct3_opmvv = 3'b010;

  // mask-register logical ops
  localparam logic [5:0] funct6_vmandn = 6'b011000;
  localparam logic [5:0] funct6_vmand  = 6'b011001;
  localparam logic [5:0] funct6_vmor   = 6'b011010;
  localparam logic [5:0] funct6_vmxor  = 6'b011011;
  localparam logic [5:0] funct6_vmorn  = 6'b011100;
  localparam logic [5:0] funct6_vmnand = 6'b011101;
  localparam logic [5:0] funct6_vmnor  = 6'b011110;
  localparam logic [5:0] funct6_vmxnor = 6'b011111;

  // unary groups, selected further by the vs1 field
  localparam logic [5:0] funct6_vwxunary0 = 6'b010000;
  localparam logic [5:0] funct6_vmunary0  = 6'b010100;

  localparam logic [4:0] vs1_vcpop  = 5'b10000;
  localparam logic [4:0] vs1_vfirst = 5'b10001;
  localparam logic [4:0] vs1_vmsbf  = 5'b00001;
  localparam logic [4:0] vs1_vmsof  = 5'b00010;
  localparam logic [4:0] vs1_vmsif  = 5'b00011;

  typedef enum logic [3:0] {
    op_none,
    op_vmandn,
    op_vmand,
    op_vmor,
    op_vmxor,
    op_vmorn,
    op_vmnand,
    op_vmnor,
    op_vmxnor,
    op_vcpop,
    op_vfirst,
    op_vmsbf,
    op_vmsif,
    op_vmsof
  } mask_op_e;

  // micro-op as issued by the reservation station
  typedef struct packed {
    rob_idx_t   rob_entry;
    logic [5:0] funct6;
    logic [2:0] funct3;
    logic [4:0] vs1;
    vl_t        vstart;
    vl_t        vl;
    logic       vm;
    vreg_t      v0_data;
    vreg_t      vd_data;
    vreg_t      vs1_data;
    vreg_t      vs2_data;
    logic       v0_data_valid;
    logic       vd_data_valid;
    logic       vs1_data_valid;
    logic       vs2_data_valid;
  } mask_uop_t;

  typedef struct packed {
    rob_idx_t rob_entry;
    mask_op_e op;
    vreg_t    src1;
    vreg_t    src2;
    vreg_t    vd_data;
    // set where the old destination bit survives
    vreg_t    keep_vd;
  } mask_operands_t;

  typedef struct packed {
    rob_idx_t rob_entry;
    vreg_t    w_data;
    logic     ignore_vta;
    logic     ignore_vma;
  } rob_result_t;

endpackage
